// ==== design/id_queue_defs.svh ====
// Size macros for the ID queue, included by the package and by every RTL module
// All widths derive from the ID width and the pool capacity
`ifndef ID_QUEUE_DEFS_SVH
`define ID_QUEUE_DEFS_SVH

// Bits of a transaction ID
`define ID_QUEUE_ID_WIDTH 2

// Number of cells in the linked data pool
`define ID_QUEUE_CAPACITY 8

// Bits of one stored data word
`define ID_QUEUE_DATA_WIDTH 16

// The head-tail table never needs more slots than there are IDs or pool cells
`define ID_QUEUE_HT_ENTRIES ((1 << `ID_QUEUE_ID_WIDTH) < `ID_QUEUE_CAPACITY ? \
    (1 << `ID_QUEUE_ID_WIDTH) : `ID_QUEUE_CAPACITY)

// Index widths for the table and the pool
`define ID_QUEUE_HT_IDX_WIDTH $clog2(`ID_QUEUE_HT_ENTRIES)
`define ID_QUEUE_LD_IDX_WIDTH $clog2(`ID_QUEUE_CAPACITY)

`endif

// ==== design/id_queue_pkg.sv ====
// Vector types of the ID queue, shared by the RTL blocks and the testbench
// Import it wherever IDs, data words or table indices are declared
`default_nettype none

`include "id_queue_defs.svh"

package id_queue_pkg;

    // Transaction ID that selects the per-ID FIFO
    typedef logic [`ID_QUEUE_ID_WIDTH-1:0] id_t;

    // Stored word, also used as search pattern and search mask
    typedef logic [`ID_QUEUE_DATA_WIDTH-1:0] data_t;

    // Slot number in the head-tail table
    typedef logic [`ID_QUEUE_HT_IDX_WIDTH-1:0] ht_idx_t;

    // Cell number in the linked data pool
    typedef logic [`ID_QUEUE_LD_IDX_WIDTH-1:0] ld_idx_t;

endpackage

`default_nettype wire

// ==== design/ht_table.sv ====
// Head-tail table with one slot per live ID, holding the first and last pool cell of its list
// Lookups are combinational and the update strobes take effect on the next clock edge
`timescale 1ns/1ps
`default_nettype none

`include "id_queue_defs.svh"

module ht_table (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire id_queue_pkg::id_t     lookup_id_i,
    input  wire id_queue_pkg::ld_idx_t new_idx_i,
    input  wire id_queue_pkg::ld_idx_t head_next_i,
    input  wire logic                  alloc_i,
    input  wire logic                  append_i,
    input  wire logic                  advance_i,
    input  wire logic                  release_i,
    output logic                       hit_o,
    output id_queue_pkg::ld_idx_t      hit_head_o,
    output id_queue_pkg::ld_idx_t      hit_tail_o
);

    import id_queue_pkg::*;

    // Each slot holds an ID, a head and a tail and is live while its free bit is low
    id_t     id_q   [`ID_QUEUE_HT_ENTRIES];
    ld_idx_t head_q [`ID_QUEUE_HT_ENTRIES];
    ld_idx_t tail_q [`ID_QUEUE_HT_ENTRIES];
    logic [`ID_QUEUE_HT_ENTRIES-1:0] free_q;

    logic [`ID_QUEUE_HT_ENTRIES-1:0] match;
    ht_idx_t match_idx;
    ht_idx_t free_idx;

    // A used slot matches when its stored ID equals the lookup ID
    always_comb begin
        for (int i = 0; i < `ID_QUEUE_HT_ENTRIES; i++) begin
            match[i] = !free_q[i] && (id_q[i] == lookup_id_i);
        end
    end

    // At most one slot holds a given ID, so OR-ing the indices gives the binary slot number
    always_comb begin
        match_idx = '0;
        for (int i = 0; i < `ID_QUEUE_HT_ENTRIES; i++) begin
            if (match[i]) begin
                match_idx = match_idx | ht_idx_t'(i);
            end
        end
    end

    // Scan from the top down so the lowest free slot is the last one to win
    always_comb begin
        free_idx = '0;
        for (int i = `ID_QUEUE_HT_ENTRIES - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                free_idx = ht_idx_t'(i);
            end
        end
    end

    assign hit_o      = |match;
    assign hit_head_o = head_q[match_idx];
    assign hit_tail_o = tail_q[match_idx];

    // Slot occupancy
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            free_q <= '1;
        end else if (alloc_i) begin
            free_q[free_idx] <= 1'b0;
        end else if (release_i) begin
            free_q[match_idx] <= 1'b1;
        end
    end

    // A new slot starts as a one-cell list
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            id_q[free_idx]   <= lookup_id_i;
            head_q[free_idx] <= new_idx_i;
            tail_q[free_idx] <= new_idx_i;
        end else if (append_i) begin
            tail_q[match_idx] <= new_idx_i;
        end else if (advance_i) begin
            // The head follows the link stored in the cell it leaves
            head_q[match_idx] <= head_next_i;
        end
    end

    // A new ID only arrives while some slot is free, which holds as long as the
    // table has one slot per possible ID
    assert property (@(posedge clk_i) disable iff (!rst_ni) alloc_i |-> |free_q)
        else $error("head-tail table allocation with no free slot");

endmodule

`default_nettype wire

// ==== design/ld_pool.sv ====
// Linked data pool that stores the queued words with one next link per cell
// Reads are combinational by index and writes, links and frees land on the next clock edge
`timescale 1ns/1ps
`default_nettype none

`include "id_queue_defs.svh"

module ld_pool (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  wr_i,
    input  wire id_queue_pkg::data_t   wr_data_i,
    input  wire logic                  link_i,
    input  wire id_queue_pkg::ld_idx_t link_idx_i,
    input  wire logic                  free_i,
    input  wire id_queue_pkg::ld_idx_t rd_idx_i,
    output id_queue_pkg::ld_idx_t      new_idx_o,
    output logic                       full_o,
    output id_queue_pkg::data_t        rd_data_o,
    output id_queue_pkg::ld_idx_t      rd_next_o,
    output id_queue_pkg::data_t [`ID_QUEUE_CAPACITY-1:0] entries_o,
    output logic [`ID_QUEUE_CAPACITY-1:0] used_o
);

    import id_queue_pkg::*;

    // One data word, one next link and one used flag per cell
    data_t [`ID_QUEUE_CAPACITY-1:0] data_q;
    ld_idx_t next_q [`ID_QUEUE_CAPACITY];
    logic [`ID_QUEUE_CAPACITY-1:0] used_q;

    ld_idx_t free_idx;

    // The lowest unused cell is found by scanning downwards
    always_comb begin
        free_idx = '0;
        for (int i = `ID_QUEUE_CAPACITY - 1; i >= 0; i--) begin
            if (!used_q[i]) begin
                free_idx = ld_idx_t'(i);
            end
        end
    end

    assign new_idx_o = free_idx;
    assign full_o    = &used_q;

    // The read index is the head of the looked up ID
    assign rd_data_o = data_q[rd_idx_i];
    assign rd_next_o = next_q[rd_idx_i];

    // The exists search sees the whole pool at once
    assign entries_o = data_q;
    assign used_o    = used_q;

    // A write and a free never come in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            used_q <= '0;
        end else begin
            if (wr_i) begin
                used_q[free_idx] <= 1'b1;
            end
            if (free_i) begin
                used_q[rd_idx_i] <= 1'b0;
            end
        end
    end

    // Data and links
    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            data_q[free_idx] <= wr_data_i;
        end
        // The old tail cell now points at the cell that is being filled
        if (link_i) begin
            next_q[link_idx_i] <= free_idx;
        end
    end

    // The controller must hold off pushes once the last free cell is taken
    assert property (@(posedge clk_i) disable iff (!rst_ni) wr_i |-> !full_o)
        else $error("pool write while full");

endmodule

`default_nettype wire

// ==== design/exists_search.sv ====
// Masked search over every used pool cell, answering in the cycle of the request
// Only bits that are set in the mask take part in the comparison
`timescale 1ns/1ps
`default_nettype none

`include "id_queue_defs.svh"

module exists_search (
    input  wire id_queue_pkg::data_t [`ID_QUEUE_CAPACITY-1:0] entries_i,
    input  wire logic [`ID_QUEUE_CAPACITY-1:0]                used_i,
    input  wire id_queue_pkg::data_t                          exists_data_i,
    input  wire id_queue_pkg::data_t                          exists_mask_i,
    input  wire logic                                         exists_req_i,
    output logic                                              exists_o,
    output logic                                              exists_gnt_o
);

    import id_queue_pkg::*;

    logic [`ID_QUEUE_CAPACITY-1:0] cell_match;

    // A cell matches when it is used and no compared bit differs
    always_comb begin
        data_t diff;
        for (int i = 0; i < `ID_QUEUE_CAPACITY; i++) begin
            diff          = (entries_i[i] ^ exists_data_i) & exists_mask_i;
            cell_match[i] = used_i[i] && (diff == '0);
        end
    end

    // The search port is always granted when asked and silent otherwise
    assign exists_gnt_o = exists_req_i;
    assign exists_o     = exists_req_i && (|cell_match);

endmodule

`default_nettype wire

// ==== design/queue_ctrl.sv ====
// Arbiter between push and output access, producing the table and pool update strobes
// Pure combinational logic, one of the two ports is served per cycle
`timescale 1ns/1ps
`default_nettype none

module queue_ctrl (
    input  wire logic                  inp_req_i,
    input  wire id_queue_pkg::id_t     inp_id_i,
    input  wire logic                  oup_req_i,
    input  wire id_queue_pkg::id_t     oup_id_i,
    input  wire logic                  oup_pop_i,
    input  wire logic                  full_i,
    input  wire logic                  hit_i,
    input  wire id_queue_pkg::ld_idx_t head_i,
    input  wire id_queue_pkg::ld_idx_t tail_i,
    input  wire id_queue_pkg::data_t   rd_data_i,
    output logic                       inp_gnt_o,
    output logic                       oup_gnt_o,
    output id_queue_pkg::data_t        oup_data_o,
    output logic                       oup_data_valid_o,
    output id_queue_pkg::id_t          lookup_id_o,
    output logic                       alloc_o,
    output logic                       append_o,
    output logic                       advance_o,
    output logic                       release_o,
    output logic                       wr_o,
    output logic                       link_o,
    output logic                       free_o
);

    logic push;
    logic present;
    logic pop;
    logic last_cell;

    // The input port wins whenever it asks and the pool has room
    assign inp_gnt_o = !full_i;
    assign push      = inp_req_i && !full_i;

    // The output port gets the cycle only when no push takes it
    assign oup_gnt_o = oup_req_i && !push;

    // The table is looked up with the ID of whichever port is served
    assign lookup_id_o = push ? inp_id_i : oup_id_i;

    // Push side
    // A push always fills the free pool cell
    assign wr_o = push;

    // Absent ID opens a new table slot, present ID extends its list
    assign alloc_o  = push && !hit_i;
    assign append_o = push && hit_i;
    assign link_o   = push && hit_i;

    // Output side
    // An absent ID is still granted but returns no data
    assign present          = oup_gnt_o && hit_i;
    assign oup_data_valid_o = present;
    assign oup_data_o       = present ? rd_data_i : '0;

    // Popping the only cell of an ID empties its slot
    assign pop       = present && oup_pop_i;
    assign last_cell = (head_i == tail_i);

    assign free_o    = pop;
    assign release_o = pop && last_cell;
    assign advance_o = pop && !last_cell;

    // A push goes either to a new slot or to an existing one, never both
    always_comb begin
        assert (!(alloc_o && append_o))
            else $error("push both allocates and appends");
    end

endmodule

`default_nettype wire

// ==== design/id_queue_top.sv ====
// ID queue top level with push, read or pop, and masked exists ports
// Entries with the same ID leave in arrival order; all responses are combinational
`timescale 1ns/1ps
`default_nettype none

`include "id_queue_defs.svh"

module id_queue_top (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,

    input  wire id_queue_pkg::id_t   inp_id_i,
    input  wire id_queue_pkg::data_t inp_data_i,
    input  wire logic                inp_req_i,
    output logic                     inp_gnt_o,

    input  wire id_queue_pkg::data_t exists_data_i,
    input  wire id_queue_pkg::data_t exists_mask_i,
    input  wire logic                exists_req_i,
    output logic                     exists_o,
    output logic                     exists_gnt_o,

    input  wire id_queue_pkg::id_t   oup_id_i,
    input  wire logic                oup_pop_i,
    input  wire logic                oup_req_i,
    output id_queue_pkg::data_t      oup_data_o,
    output logic                     oup_data_valid_o,
    output logic                     oup_gnt_o
);

    import id_queue_pkg::*;

    // Lookup result of the served port
    id_t     lookup_id;
    logic    hit;
    ld_idx_t hit_head;
    ld_idx_t hit_tail;

    // Table update strobes
    logic ht_alloc;
    logic ht_append;
    logic ht_advance;
    logic ht_release;

    // Pool update strobes and read side
    logic    ld_wr;
    logic    ld_link;
    logic    ld_free;
    logic    full;
    ld_idx_t new_idx;
    ld_idx_t head_next;
    data_t   rd_data;

    // Whole pool as seen by the search
    data_t [`ID_QUEUE_CAPACITY-1:0] entries;
    logic  [`ID_QUEUE_CAPACITY-1:0] used;

    queue_ctrl u_queue_ctrl (
        .inp_req_i        (inp_req_i),
        .inp_id_i         (inp_id_i),
        .oup_req_i        (oup_req_i),
        .oup_id_i         (oup_id_i),
        .oup_pop_i        (oup_pop_i),
        .full_i           (full),
        .hit_i            (hit),
        .head_i           (hit_head),
        .tail_i           (hit_tail),
        .rd_data_i        (rd_data),
        .inp_gnt_o        (inp_gnt_o),
        .oup_gnt_o        (oup_gnt_o),
        .oup_data_o       (oup_data_o),
        .oup_data_valid_o (oup_data_valid_o),
        .lookup_id_o      (lookup_id),
        .alloc_o          (ht_alloc),
        .append_o         (ht_append),
        .advance_o        (ht_advance),
        .release_o        (ht_release),
        .wr_o             (ld_wr),
        .link_o           (ld_link),
        .free_o           (ld_free)
    );

    ht_table u_ht_table (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .lookup_id_i (lookup_id),
        .new_idx_i   (new_idx),
        .head_next_i (head_next),
        .alloc_i     (ht_alloc),
        .append_i    (ht_append),
        .advance_i   (ht_advance),
        .release_i   (ht_release),
        .hit_o       (hit),
        .hit_head_o  (hit_head),
        .hit_tail_o  (hit_tail)
    );

    // The pool links behind the matched tail and reads or frees the matched head
    ld_pool u_ld_pool (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .wr_i       (ld_wr),
        .wr_data_i  (inp_data_i),
        .link_i     (ld_link),
        .link_idx_i (hit_tail),
        .free_i     (ld_free),
        .rd_idx_i   (hit_head),
        .new_idx_o  (new_idx),
        .full_o     (full),
        .rd_data_o  (rd_data),
        .rd_next_o  (head_next),
        .entries_o  (entries),
        .used_o     (used)
    );

    exists_search u_exists_search (
        .entries_i     (entries),
        .used_i        (used),
        .exists_data_i (exists_data_i),
        .exists_mask_i (exists_mask_i),
        .exists_req_i  (exists_req_i),
        .exists_o      (exists_o),
        .exists_gnt_o  (exists_gnt_o)
    );

endmodule

`default_nettype wire

// ==== tb/tb_id_queue.sv ====
// Self-checking testbench for the ID queue, a per-ID model predicts every output each cycle
// Directed tests run first, then random traffic; compile it as the simulation top
`timescale 1ns/1ps
`default_nettype none

`include "id_queue_defs.svh"

module tb_id_queue;

    import id_queue_pkg::*;

    localparam int NUM_IDS    = 1 << `ID_QUEUE_ID_WIDTH;
    localparam int WAIT_LIMIT = 32;

    logic  clk_i;
    logic  rst_ni;
    logic  inp_req;
    id_t   inp_id;
    data_t inp_data;
    logic  inp_gnt;
    logic  oup_req;
    id_t   oup_id;
    logic  oup_pop;
    data_t oup_data;
    logic  oup_valid;
    logic  oup_gnt;
    logic  ex_req;
    data_t ex_data;
    data_t ex_mask;
    logic  ex_hit;
    logic  ex_gnt;

    // One FIFO per ID holds what the DUT should be storing
    data_t       model_q [NUM_IDS][$];
    logic [31:0] lcg_state = 32'h7919;
    int          err_cnt = 0;
    int          chk_cnt = 0;

    id_queue_top u_id_queue_top (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .inp_id_i         (inp_id),
        .inp_data_i       (inp_data),
        .inp_req_i        (inp_req),
        .inp_gnt_o        (inp_gnt),
        .exists_data_i    (ex_data),
        .exists_mask_i    (ex_mask),
        .exists_req_i     (ex_req),
        .exists_o         (ex_hit),
        .exists_gnt_o     (ex_gnt),
        .oup_id_i         (oup_id),
        .oup_pop_i        (oup_pop),
        .oup_req_i        (oup_req),
        .oup_data_o       (oup_data),
        .oup_data_valid_o (oup_valid),
        .oup_gnt_o        (oup_gnt)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected {inp_gnt, oup_gnt, valid, exists_gnt, exists, data} for the inputs now applied
    function automatic logic [20:0] expected_outputs();
        int    count;
        logic  full;
        logic  gnt;
        logic  valid;
        logic  found;
        data_t head;
        count = 0;
        found = 1'b0;
        head  = '0;
        for (int i = 0; i < NUM_IDS; i++) begin
            count += model_q[i].size();
            for (int j = 0; j < model_q[i].size(); j++) begin
                if (((model_q[i][j] ^ ex_data) & ex_mask) == '0) begin
                    found = 1'b1;
                end
            end
        end
        full = (count == `ID_QUEUE_CAPACITY);
        // A push that is granted takes the cycle away from the output port
        gnt   = oup_req && !(inp_req && !full);
        valid = gnt && (model_q[oup_id].size() != 0);
        if (valid) begin
            head = model_q[oup_id][0];
        end
        return {!full, gnt, valid, ex_req, ex_req && found, head};
    endfunction

    task automatic compare_value(input string name, input data_t got, input data_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
        end
    endtask

    // Compare shortly before each rising edge, then follow any granted push or pop
    always @(negedge clk_i) begin
        logic [20:0] expected;
        #4;
        if (rst_ni) begin
            expected = expected_outputs();
            compare_value("inp_gnt_o", data_t'(inp_gnt), data_t'(expected[20]));
            compare_value("oup_gnt_o", data_t'(oup_gnt), data_t'(expected[19]));
            compare_value("oup_data_valid_o", data_t'(oup_valid), data_t'(expected[18]));
            compare_value("exists_gnt_o", data_t'(ex_gnt), data_t'(expected[17]));
            compare_value("exists_o", data_t'(ex_hit), data_t'(expected[16]));
            compare_value("oup_data_o", oup_data, expected[15:0]);
            if (inp_req && expected[20]) begin
                model_q[inp_id].push_back(inp_data);
            end
            if (expected[18] && oup_pop) begin
                void'(model_q[oup_id].pop_front());
            end
        end
    end

    // One cycle of port requests at the falling edge, with a random search beside them
    task automatic apply_cycle(input logic i_req, input id_t i_id, input data_t i_data,
                               input logic o_req, input id_t o_id, input logic o_pop);
        logic [31:0] r;
        logic [31:0] m;
        r = lcg_next();
        m = lcg_next();
        @(negedge clk_i);
        inp_req  = i_req;
        inp_id   = i_id;
        inp_data = i_data;
        oup_req  = o_req;
        oup_id   = o_id;
        oup_pop  = o_pop;
        ex_req   = r[15] | r[14];
        ex_data  = r[31:16];
        // Two random words ANDed leave few mask bits, so hits are frequent
        ex_mask  = m[31:16] & m[23:8];
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("%0d checks, %0d errors", chk_cnt, err_cnt + 1);
        $display("TEST FAILED");
        $finish;
    endtask

    // Pop every ID until it answers empty while the model checks the order of the data
    task automatic drain_queue();
        int waited;
        for (int i = 0; i < NUM_IDS; i++) begin
            waited = 0;
            do begin
                apply_cycle(1'b0, '0, '0, 1'b1, id_t'(i), 1'b1);
                #4;
                waited++;
            end while (oup_valid && waited < WAIT_LIMIT);
            if (oup_valid) begin
                stop_on_timeout("an ID did not run empty");
            end else begin
                // The last request found the ID absent, yet it was granted with zero data
                compare_value("oup_gnt_o", data_t'(oup_gnt), 16'h1);
                compare_value("oup_data_o", oup_data, '0);
            end
        end
    endtask

    // The last cycle of a test is checked just before this rising edge
    task automatic print_result(input string name, input int errs_before);
        @(posedge clk_i);
        $display("%s test finished with %0d errors", name, err_cnt - errs_before);
    endtask

    initial begin
        logic [31:0] r;
        data_t       first;
        id_t         first_id;
        int          errs;
        int          waited;
        clk_i    = 1'b0;
        rst_ni   = 1'b0;
        inp_req  = 1'b0;
        inp_id   = '0;
        inp_data = '0;
        oup_req  = 1'b0;
        oup_id   = '0;
        oup_pop  = 1'b0;
        ex_req   = 1'b0;
        ex_data  = '0;
        ex_mask  = '0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // Empty queue: push granted, no ID valid, and even a zero mask finds nothing
        errs = err_cnt;
        for (int i = 0; i < NUM_IDS; i++) begin
            apply_cycle(1'b0, '0, '0, 1'b1, id_t'(i), 1'b0);
            ex_req  = 1'b1;
            ex_mask = '0;
            #4;
            compare_value("inp_gnt_o", data_t'(inp_gnt), 16'h1);
            compare_value("oup_data_valid_o", data_t'(oup_valid), 16'h0);
            compare_value("exists_o", data_t'(ex_hit), 16'h0);
        end
        print_result("reset", errs);

        errs = err_cnt;
        for (int n = 0; n < `ID_QUEUE_CAPACITY; n++) begin
            r = lcg_next();
            apply_cycle(1'b1, r[31:30], r[23:8], 1'b0, '0, 1'b0);
        end
        drain_queue();
        print_result("order", errs);

        // Two reads leave the head in place and the third access pops it
        errs = err_cnt;
        r = lcg_next();
        first = r[23:8];
        apply_cycle(1'b1, 2'd2, first, 1'b0, '0, 1'b0);
        apply_cycle(1'b1, 2'd2, ~first, 1'b0, '0, 1'b0);
        for (int n = 0; n < 3; n++) begin
            apply_cycle(1'b0, '0, '0, 1'b1, 2'd2, n == 2);
            #4;
            compare_value("oup_data_o", oup_data, first);
        end
        drain_queue();
        print_result("read", errs);

        errs = err_cnt;
        r = lcg_next();
        first_id = r[31:30];
        apply_cycle(1'b1, first_id, r[23:8], 1'b1, first_id, 1'b1);
        #4;
        compare_value("oup_gnt_o", data_t'(oup_gnt), 16'h0);
        waited = 0;
        do begin
            r = lcg_next();
            apply_cycle(1'b1, r[31:30], r[23:8], 1'b0, '0, 1'b0);
            #4;
            waited++;
        end while (inp_gnt && waited < WAIT_LIMIT);
        if (inp_gnt) begin
            stop_on_timeout("the queue never refused a push");
        end else if (waited != `ID_QUEUE_CAPACITY) begin
            err_cnt++;
            $display("the queue filled after %0d pushes instead of %0d",
                     waited, `ID_QUEUE_CAPACITY);
        end
        // Full queue serves the output port, and the freed cell takes the next push
        apply_cycle(1'b1, r[31:30], r[23:8], 1'b1, first_id, 1'b1);
        #4;
        compare_value("oup_gnt_o", data_t'(oup_gnt), 16'h1);
        compare_value("oup_data_valid_o", data_t'(oup_valid), 16'h1);
        apply_cycle(1'b1, r[31:30], r[23:8], 1'b0, '0, 1'b0);
        #4;
        compare_value("inp_gnt_o", data_t'(inp_gnt), 16'h1);
        drain_queue();
        print_result("full", errs);

        errs = err_cnt;
        for (int n = 0; n < 48; n++) begin
            r = lcg_next();
            apply_cycle(n < 6, r[31:30], r[23:8], n >= 6, r[29:28], 1'b0);
        end
        drain_queue();
        print_result("exists", errs);

        errs = err_cnt;
        for (int n = 0; n < 400; n++) begin
            r = lcg_next();
            apply_cycle(r[31] & r[30], r[29:28], r[23:8], r[27] | r[26], r[25:24], r[20]);
        end
        drain_queue();
        print_result("random", errs);

        $display("%0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== id_queue.f ====
+incdir+design
design/id_queue_pkg.sv
design/ht_table.sv
design/ld_pool.sv
design/exists_search.sv
design/queue_ctrl.sv
design/id_queue_top.sv
tb/tb_id_queue.sv

// ==== Makefile ====
# Verilator build and run of the ID queue testbench
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := tb_id_queue
FILELIST := id_queue.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# The run passes only when the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)
